// ==== arcade_io_assert.sv ====
`timescale 1ns/100ps
`default_nettype none

module video_checks import arcade_io_pkg::*; (
	input logic                 clock_24,
	input logic                 rst_n,
	input logic                 ce_pix,
	input logic                 hb,
	input logic                 vb,
	input logic                 hs,
	input logic                 vs,
	input logic [vga_width-1:0] vga_r,
	input logic [vga_width-1:0] vga_g,
	input logic [vga_width-1:0] vga_b,
	input logic                 vga_hs,
	input logic                 vga_vs
);
	int fail_count = 0;

	blank_zero: assert property (@(posedge clock_24) disable iff (!rst_n)
		ce_pix && (hb || vb) |=> vga_r == '0 && vga_g == '0 && vga_b == '0)
		else begin
			$error("colour not zero after a blanked pixel");
			fail_count++;
		end

	hs_delay: assert property (@(posedge clock_24) disable iff (!rst_n)
		ce_pix |=> vga_hs == $past(hs))
		else begin
			$error("vga_hs does not follow hs");
			fail_count++;
		end

	vs_delay: assert property (@(posedge clock_24) disable iff (!rst_n)
		ce_pix |=> vga_vs == $past(vs))
		else begin
			$error("vga_vs does not follow vs");
			fail_count++;
		end

	// register stage only moves on a pixel enable
	hold_idle: assert property (@(posedge clock_24) disable iff (!rst_n)
		!ce_pix |=> $stable({vga_r, vga_g, vga_b, vga_hs, vga_vs}))
		else begin
			$error("video outputs changed without ce_pix");
			fail_count++;
		end
endmodule

bind video_blank_dim video_checks video_checks_i (
	.clock_24 (clock_24), .rst_n (rst_n), .ce_pix (ce_pix),
	.hb (hb), .vb (vb), .hs (hs), .vs (vs),
	.vga_r (vga_r), .vga_g (vga_g), .vga_b (vga_b), .vga_hs (vga_hs), .vga_vs (vga_vs)
);

`default_nettype wire

// ==== arcade_io_pkg.sv ====
`default_nettype none

package arcade_io_pkg;

	// host command bytes
	localparam logic [7:0] cmd_status = 8'h1E; // 4 payload bytes, lsb first
	localparam logic [7:0] cmd_joy0   = 8'h01;
	localparam logic [7:0] cmd_joy1   = 8'h02;
	localparam logic [7:0] cmd_key    = 8'h05; // scan code, then pressed flag

	localparam int status_bytes = 4;

	// status word fields
	localparam int st_reset_bit  = 0;
	localparam int st_scan_lo    = 3; // scanline field is bits 4:3
	localparam int st_pause_bit  = 5;
	localparam int st_reset2_bit = 6;

	// ps/2 set 2 scan codes
	localparam logic [7:0] key_left   = 8'h6B;
	localparam logic [7:0] key_right  = 8'h74;
	localparam logic [7:0] key_coin   = 8'h76; // esc
	localparam logic [7:0] key_start1 = 8'h05; // f1
	localparam logic [7:0] key_start2 = 8'h06; // f2
	localparam logic [7:0] key_fire   = 8'h29; // space

	localparam int joy_right_bit = 0;
	localparam int joy_left_bit  = 1;
	localparam int joy_fire_bit  = 4;

	// colour widths in and out of the video stage
	localparam int rg_width  = 3;
	localparam int b_width   = 2;
	localparam int vga_width = 6;

	// scanline dimming modes
	localparam logic [1:0] scan_none = 2'd0;
	localparam logic [1:0] scan_25   = 2'd1;
	localparam logic [1:0] scan_50   = 2'd2;
	localparam logic [1:0] scan_75   = 2'd3;

	localparam int dac_width = 16;

endpackage

`default_nettype wire

// ==== arcade_io_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module arcade_io_tb import arcade_io_pkg::*; ();
	localparam int n_rows = 29;
	localparam int line_px = 12;
	localparam int frame_lines = 6;
	localparam int spi_cycles = (1 + status_bytes) * 8 * 8 + 12; // longest transaction
	localparam int frame_cycles = line_px * frame_lines * 4;
	localparam int dac_cycles = 4096 + 8;
	localparam int run_cycles = 20 + n_rows * spi_cycles + 5 * (frame_cycles + spi_cycles)
		+ 4 * dac_cycles;
	localparam int cycle_limit = run_cycles * 6 / 5;

	// controls are {left, right, fire, coin, start1, start2}
	typedef struct packed {
		logic [2:0]  grp;
		logic [7:0]  cmd;
		logic [31:0] payload; // sent lsb byte first
		logic [5:0]  ctl;
		logic        rst;
		logic        pause;
	} row_t;

	logic clock_24;
	logic rst_n;
	logic [1:0] ce_cnt = 2'd0;
	logic ce_pix;
	logic spi_sck;
	logic spi_ss_n;
	logic spi_di;
	logic [2:0] core_r;
	logic [2:0] core_g;
	logic [1:0] core_b;
	logic core_hb;
	logic core_vb;
	logic core_hs;
	logic core_vs;
	logic [7:0] audio;
	logic [5:0] vga_r;
	logic [5:0] vga_g;
	logic [5:0] vga_b;
	logic vga_hs;
	logic vga_vs;
	logic audio_l;
	logic audio_r;
	logic game_reset;
	logic game_pause;
	logic left;
	logic right;
	logic fire;
	logic coin;
	logic start1;
	logic start2;
	logic [5:0] controls;

	row_t table_rows [n_rows];
	int row_count = 0;
	int errors = 0;
	int checks = 0;
	int tests_failed = 0;
	int err_mark;
	int cycles;
	logic [31:0] lfsr_state = 32'he0f25fd2;
	logic [1:0] scan_sel = 2'd0;
	logic odd_m = 1'b0; // model of the odd-line flag
	logic prev_hs = 1'b0;
	logic have_exp = 1'b0;
	logic [19:0] exp_px;

	arcade_io_top arcade_io_top_i (
		.clock_24 (clock_24), .rst_n (rst_n), .ce_pix (ce_pix),
		.spi_sck (spi_sck), .spi_ss_n (spi_ss_n), .spi_di (spi_di),
		.core_r (core_r), .core_g (core_g), .core_b (core_b),
		.core_hb (core_hb), .core_vb (core_vb), .core_hs (core_hs), .core_vs (core_vs),
		.audio (audio),
		.vga_r (vga_r), .vga_g (vga_g), .vga_b (vga_b), .vga_hs (vga_hs), .vga_vs (vga_vs),
		.audio_l (audio_l), .audio_r (audio_r),
		.game_reset (game_reset), .game_pause (game_pause),
		.left (left), .right (right), .fire (fire),
		.coin (coin), .start1 (start1), .start2 (start2)
	);

	assign controls = {left, right, fire, coin, start1, start2};
	assign ce_pix   = (ce_cnt == 2'd3); // every fourth cycle

	initial begin
		clock_24 = 1'b0;
		forever #50 clock_24 = ~clock_24;
	end

	always @(negedge clock_24)
		ce_cnt <= ce_cnt + 2'd1;

	initial begin
		cycles = 0;
		while (cycles < cycle_limit) begin
			@(posedge clock_24);
			cycles++;
		end
		$display("error: run timed out after %0d clock cycles", cycles);
		$display("SOME TESTS FAILED");
		$finish;
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [7:0] random_bits(input int n);
		logic [7:0] v;
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[6:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic int widen(input int v, input int bits);
		return (bits == 3) ? v * 9 : v * 21;
	endfunction

	function automatic int dimmed(input int v, input int m);
		case (m)
			1: return v - v / 4;
			2: return v / 2;
			3: return v / 4;
			default: return v;
		endcase
	endfunction

	function automatic int payload_len(input logic [7:0] c);
		case (c)
			cmd_status: return status_bytes;
			cmd_key: return 2;
			default: return 1;
		endcase
	endfunction

	function automatic string test_name(input int n);
		case (n)
			1: return "status word";
			2: return "joysticks";
			3: return "key events";
			4: return "blanking and expansion";
			5: return "scanline dimming";
			default: return "audio dac";
		endcase
	endfunction

	task automatic add_row(input int grp, input logic [7:0] cmd, input logic [31:0] payload,
			input logic [5:0] ctl, input logic rst, input logic pause);
		table_rows[row_count] = {grp[2:0], cmd, payload, ctl, rst, pause};
		row_count++;
	endtask

	task automatic load_table();
		add_row(1, cmd_status, 32'h01, 6'b000000, 1, 0);
		add_row(1, cmd_status, 32'h20, 6'b000000, 0, 1);
		add_row(1, cmd_status, 32'h40, 6'b000000, 1, 0);
		add_row(1, cmd_status, 32'h61, 6'b000000, 1, 1);
		add_row(1, cmd_status, 32'h00, 6'b000000, 0, 0);
		add_row(2, cmd_joy0, 32'h01, 6'b010000, 0, 0);
		add_row(2, cmd_joy0, 32'h13, 6'b111000, 0, 0);
		add_row(2, cmd_joy1, 32'h02, 6'b111000, 0, 0);
		add_row(2, cmd_joy0, 32'h00, 6'b100000, 0, 0); // joy1 still holds left
		add_row(2, cmd_joy1, 32'h12, 6'b101000, 0, 0);
		add_row(2, cmd_joy1, 32'h00, 6'b000000, 0, 0);
		add_row(3, cmd_key, 32'h016B, 6'b100000, 0, 0);
		add_row(3, cmd_key, 32'h006B, 6'b000000, 0, 0);
		add_row(3, cmd_key, 32'h0174, 6'b010000, 0, 0);
		add_row(3, cmd_key, 32'h0074, 6'b000000, 0, 0);
		add_row(3, cmd_key, 32'h0129, 6'b001000, 0, 0);
		add_row(3, cmd_key, 32'h0029, 6'b000000, 0, 0);
		add_row(3, cmd_key, 32'h0176, 6'b000100, 0, 0);
		add_row(3, cmd_key, 32'h0076, 6'b000000, 0, 0);
		add_row(3, cmd_key, 32'h0105, 6'b000010, 0, 0);
		add_row(3, cmd_key, 32'h0005, 6'b000000, 0, 0);
		add_row(3, cmd_key, 32'h0106, 6'b000001, 0, 0);
		add_row(3, cmd_key, 32'h0006, 6'b000000, 0, 0);
		add_row(3, cmd_key, 32'h011C, 6'b000000, 0, 0); // not a mapped key
		add_row(3, 8'h33, 32'hFF, 6'b000000, 0, 0); // unknown command
		add_row(3, cmd_key, 32'h016B, 6'b100000, 0, 0);
		add_row(3, cmd_joy0, 32'h02, 6'b100000, 0, 0);
		add_row(3, cmd_key, 32'h006B, 6'b100000, 0, 0);
		add_row(3, cmd_joy0, 32'h00, 6'b000000, 0, 0);
	endtask

	task automatic spi_write(input logic [7:0] c, input logic [31:0] p);
		int n;
		int i;
		int k;
		logic [7:0] byte_v;
		n = payload_len(c);
		@(negedge clock_24);
		spi_ss_n = 1'b0;
		repeat (4) @(negedge clock_24);
		for (i = 0; i <= n; i++) begin
			byte_v = (i == 0) ? c : p[8 * (i - 1) +: 8];
			for (k = 7; k >= 0; k--) begin
				spi_di  = byte_v[k];
				spi_sck = 1'b0;
				repeat (4) @(negedge clock_24);
				spi_sck = 1'b1;
				repeat (4) @(negedge clock_24);
			end
		end
		spi_sck  = 1'b0;
		spi_ss_n = 1'b1;
		repeat (6) @(negedge clock_24);
	endtask

	task automatic check_controls(input row_t row);
		checks++;
		assert (controls == row.ctl && game_reset == row.rst && game_pause == row.pause)
		else begin
			$display("** Error at %0t ns: cmd %h payload %h gives %b rst %b pause %b, %s %b %b %b",
				$time, row.cmd, row.payload, controls, game_reset, game_pause,
				"expected", row.ctl, row.rst, row.pause);
			errors++;
		end
	endtask

	task automatic report_test(input int n, input int errs);
		if (errs != 0)
			tests_failed++;
		$display("test %0d %s: %s (%0d errors)", n, test_name(n), errs == 0 ? "ok" : "failed",
			errs);
	endtask

	// outputs for the previous pixel are checked before the next one is driven
	task automatic drive_pixel(input logic hb_v, input logic vb_v, input logic hs_v,
			input logic vs_v);
		logic [2:0] r_v;
		logic [2:0] g_v;
		logic [1:0] b_v;
		int m;
		int e_r;
		int e_g;
		int e_b;
		do
			@(posedge clock_24);
		while (!ce_pix);
		@(negedge clock_24);
		if (have_exp) begin
			checks++;
			assert ({vga_r, vga_g, vga_b, vga_hs, vga_vs} == exp_px) else begin
				$display("** Error at %0t ns: video out %h, expected %h (scanlines %0d)",
					$time, {vga_r, vga_g, vga_b, vga_hs, vga_vs}, exp_px, scan_sel);
				errors++;
			end
		end
		r_v = 3'(random_bits(3));
		g_v = 3'(random_bits(3));
		b_v = 2'(random_bits(2));
		core_r  = r_v;
		core_g  = g_v;
		core_b  = b_v;
		core_hb = hb_v;
		core_vb = vb_v;
		core_hs = hs_v;
		core_vs = vs_v;
		m = odd_m ? scan_sel : 0;
		e_r = dimmed(widen(r_v, 3), m);
		e_g = dimmed(widen(g_v, 3), m);
		e_b = dimmed(widen(b_v, 2), m);
		if (hb_v || vb_v)
			exp_px = {18'b0, hs_v, vs_v};
		else
			exp_px = {e_r[5:0], e_g[5:0], e_b[5:0], hs_v, vs_v};
		if (vs_v)
			odd_m = 1'b0;
		else if (hs_v && !prev_hs)
			odd_m = !odd_m;
		prev_hs  = hs_v;
		have_exp = 1'b1;
	endtask

	task automatic run_frame();
		int line;
		int px;
		for (line = 0; line < frame_lines; line++)
			for (px = 0; px < line_px; px++)
				drive_pixel(px >= 8, line == 0, px == 9 || px == 10, line == 0); // vs on line 0
	endtask

	task automatic check_dac(input logic [7:0] level);
		int ones;
		int din;
		int diff;
		ones  = 0;
		din   = {level, level};
		audio = level;
		repeat (4) @(negedge clock_24); // let the old level drain
		repeat (4096) begin
			@(negedge clock_24);
			if (audio_l)
				ones++;
			checks++;
			assert (audio_r == audio_l) else begin
				$display("** Error at %0t ns: audio_r %b differs from audio_l %b",
					$time, audio_r, audio_l);
				errors++;
			end
		end
		diff = ones * 65536 - din * 4096;
		checks++;
		assert (diff <= 65536 && diff >= -65536) else begin
			$display("** Error at %0t ns: audio %h gave %0d ones in 4096 cycles, expected %0d",
				$time, level, ones, din / 16);
			errors++;
		end
	endtask

	initial begin
		int i;
		int s;
		rst_n    = 1'b0;
		spi_sck  = 1'b0;
		spi_ss_n = 1'b1;
		spi_di   = 1'b0;
		core_r   = '0;
		core_g   = '0;
		core_b   = '0;
		core_hb  = 1'b0;
		core_vb  = 1'b0;
		core_hs  = 1'b0;
		core_vs  = 1'b0;
		audio    = 8'h00;
		load_table();
		repeat (16) @(negedge clock_24);
		rst_n = 1'b1;
		repeat (2) @(negedge clock_24);

		err_mark = errors;
		checks++;
		assert (controls == 6'b0 && !game_reset && !game_pause && !audio_l
			&& {vga_r, vga_g, vga_b, vga_hs, vga_vs} == 20'b0) else begin
			$display("** Error at %0t ns: outputs not idle after reset", $time);
			errors++;
		end
		for (i = 0; i < n_rows; i++) begin
			spi_write(table_rows[i].cmd, table_rows[i].payload);
			check_controls(table_rows[i]);
			if (i == n_rows - 1 || table_rows[i + 1].grp != table_rows[i].grp) begin
				report_test(table_rows[i].grp, errors - err_mark);
				err_mark = errors;
			end
		end

		scan_sel = 2'd0;
		spi_write(cmd_status, 32'h0);
		run_frame();
		run_frame();
		report_test(4, errors - err_mark);
		err_mark = errors;

		for (s = 1; s < 4; s++) begin
			scan_sel = s[1:0];
			spi_write(cmd_status, {27'b0, scan_sel, 3'b000});
			run_frame();
		end
		report_test(5, errors - err_mark);
		err_mark = errors;

		check_dac(8'h00);
		check_dac(8'h40);
		check_dac(8'h80);
		check_dac(8'hFF);
		report_test(6, errors - err_mark);

		if (arcade_io_top_i.video_blank_dim_i.video_checks_i.fail_count != 0)
			$display("bound video assertions failed %0d times",
				arcade_io_top_i.video_blank_dim_i.video_checks_i.fail_count);
		errors += arcade_io_top_i.video_blank_dim_i.video_checks_i.fail_count;

		$display("6 tests, %0d failed, %0d checks, %0d errors", tests_failed, checks, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== arcade_io_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module arcade_io_top import arcade_io_pkg::*; (
	input  logic                 clock_24,
	input  logic                 rst_n,
	input  logic                 ce_pix,
	input  logic                 spi_sck,
	input  logic                 spi_ss_n,
	input  logic                 spi_di,
	input  logic [rg_width-1:0]  core_r,
	input  logic [rg_width-1:0]  core_g,
	input  logic [b_width-1:0]   core_b,
	input  logic                 core_hb,
	input  logic                 core_vb,
	input  logic                 core_hs,
	input  logic                 core_vs,
	input  logic [7:0]           audio,
	output logic [vga_width-1:0] vga_r,
	output logic [vga_width-1:0] vga_g,
	output logic [vga_width-1:0] vga_b,
	output logic                 vga_hs,
	output logic                 vga_vs,
	output logic                 audio_l,
	output logic                 audio_r,
	output logic                 game_reset,
	output logic                 game_pause,
	output logic                 left,
	output logic                 right,
	output logic                 fire,
	output logic                 coin,
	output logic                 start1,
	output logic                 start2
);
	logic [1:0] scanlines;

	user_io_if uio ();

	spi_user_io spi_user_io_i (
		.clock_24 (clock_24),
		.rst_n    (rst_n),
		.spi_sck  (spi_sck),
		.spi_ss_n (spi_ss_n),
		.spi_di   (spi_di),
		.io       (uio.host)
	);

	key_mapper key_mapper_i (
		.clock_24 (clock_24),
		.rst_n    (rst_n),
		.io       (uio.user),
		.left     (left),
		.right    (right),
		.fire     (fire),
		.coin     (coin),
		.start1   (start1),
		.start2   (start2)
	);

	// menu reset and core reset both hold the game
	assign game_reset = uio.status[st_reset_bit] | uio.status[st_reset2_bit];
	assign game_pause = uio.status[st_pause_bit];
	assign scanlines  = uio.status[st_scan_lo +: 2];

	video_blank_dim video_blank_dim_i (
		.clock_24  (clock_24),
		.rst_n     (rst_n),
		.ce_pix    (ce_pix),
		.scanlines (scanlines),
		.r         (core_r),
		.g         (core_g),
		.b         (core_b),
		.hb        (core_hb),
		.vb        (core_vb),
		.hs        (core_hs),
		.vs        (core_vs),
		.vga_r     (vga_r),
		.vga_g     (vga_g),
		.vga_b     (vga_b),
		.vga_hs    (vga_hs),
		.vga_vs    (vga_vs)
	);

	sigma_delta_dac sigma_delta_dac_i (
		.clock_24 (clock_24),
		.rst_n    (rst_n),
		.din      ({audio, audio}), // byte repeated to 16 bits
		.dout     (audio_l)
	);

	assign audio_r = audio_l; // mono

endmodule

`default_nettype wire

// ==== key_mapper.sv ====
`timescale 1ns/100ps
`default_nettype none

module key_mapper import arcade_io_pkg::*; (
	input  logic    clock_24,
	input  logic    rst_n,
	user_io_if.user io,
	output logic    left,
	output logic    right,
	output logic    fire,
	output logic    coin,
	output logic    start1,
	output logic    start2
);
	logic toggle_prev;
	logic btn_left;
	logic btn_right;
	logic btn_fire;
	logic btn_coin;
	logic btn_start1;
	logic btn_start2;

	always_ff @(posedge clock_24) begin
		if (!rst_n) begin
			toggle_prev <= 1'b0;
			btn_left    <= 1'b0;
			btn_right   <= 1'b0;
			btn_fire    <= 1'b0;
			btn_coin    <= 1'b0;
			btn_start1  <= 1'b0;
			btn_start2  <= 1'b0;
		end else begin
			toggle_prev <= io.key_toggle;
			if (io.key_toggle != toggle_prev) begin // new key event
				case (io.key_code)
					key_left:   btn_left   <= io.key_pressed;
					key_right:  btn_right  <= io.key_pressed;
					key_fire:   btn_fire   <= io.key_pressed;
					key_coin:   btn_coin   <= io.key_pressed;
					key_start1: btn_start1 <= io.key_pressed;
					key_start2: btn_start2 <= io.key_pressed;
					default: ;
				endcase
			end
		end
	end

	// keyboard or either stick
	assign left  = btn_left | io.joystick_0[joy_left_bit] | io.joystick_1[joy_left_bit];
	assign right = btn_right | io.joystick_0[joy_right_bit] | io.joystick_1[joy_right_bit];
	assign fire  = btn_fire | io.joystick_0[joy_fire_bit] | io.joystick_1[joy_fire_bit];

	assign coin   = btn_coin;
	assign start1 = btn_start1;
	assign start2 = btn_start2;

endmodule

`default_nettype wire

// ==== sigma_delta_dac.sv ====
`timescale 1ns/100ps
`default_nettype none

module sigma_delta_dac import arcade_io_pkg::*; (
	input  logic                 clock_24,
	input  logic                 rst_n,
	input  logic [dac_width-1:0] din,
	output logic                 dout
);
	logic [dac_width:0] acc; // top bit is the carry out

	always_ff @(posedge clock_24) begin
		if (!rst_n)
			acc <= '0;
		else
			acc <= {1'b0, acc[dac_width-1:0]} + {1'b0, din};
	end

	// one pulse per accumulator wrap
	assign dout = acc[dac_width];

endmodule

`default_nettype wire

// ==== sources.f ====
arcade_io_pkg.sv
user_io_if.sv
spi_user_io.sv
key_mapper.sv
video_blank_dim.sv
sigma_delta_dac.sv
arcade_io_top.sv
arcade_io_assert.sv
arcade_io_tb.sv

// ==== spi_user_io.sv ====
`timescale 1ns/100ps
`default_nettype none

module spi_user_io import arcade_io_pkg::*; (
	input  logic    clock_24,
	input  logic    rst_n,
	input  logic    spi_sck,
	input  logic    spi_ss_n,
	input  logic    spi_di,
	user_io_if.host io
);
	logic [1:0]  sck_sync;
	logic [1:0]  di_sync;
	logic [1:0]  ss_sync;
	logic        sck_prev;
	logic        sck_rise;
	logic [2:0]  bit_cnt;
	logic [2:0]  byte_cnt;
	logic [7:0]  cmd;
	logic [6:0]  shreg;
	logic [7:0]  byte_in;
	logic [23:0] pbuf; // earlier payload bytes, newest on top

	assign sck_rise = sck_sync[1] & ~sck_prev;
	assign byte_in  = {shreg, di_sync[1]}; // byte as it completes

	always_ff @(posedge clock_24) begin
		if (!rst_n) begin
			sck_sync <= 2'b00;
			di_sync  <= 2'b00;
			ss_sync  <= 2'b11; // deselected
			sck_prev <= 1'b0;
		end else begin
			sck_sync <= {sck_sync[0], spi_sck};
			di_sync  <= {di_sync[0], spi_di};
			ss_sync  <= {ss_sync[0], spi_ss_n};
			sck_prev <= sck_sync[1];
		end
	end

	always_ff @(posedge clock_24) begin
		if (sck_rise) begin
			shreg <= byte_in[6:0];
			if (bit_cnt == 3'd7 && byte_cnt != 3'd0)
				pbuf <= {byte_in, pbuf[23:8]};
		end
	end

	always_ff @(posedge clock_24) begin
		if (!rst_n) begin
			bit_cnt        <= 3'd0;
			byte_cnt       <= 3'd0;
			cmd            <= 8'h00;
			io.status      <= 32'h0;
			io.joystick_0  <= 8'h00;
			io.joystick_1  <= 8'h00;
			io.key_code    <= 8'h00;
			io.key_pressed <= 1'b0;
			io.key_toggle  <= 1'b0;
		end else if (ss_sync[1]) begin
			bit_cnt  <= 3'd0;
			byte_cnt <= 3'd0;
		end else if (sck_rise) begin
			bit_cnt <= bit_cnt + 3'd1;
			if (bit_cnt == 3'd7) begin
				if (byte_cnt != 3'd7)
					byte_cnt <= byte_cnt + 3'd1; // extra bytes just saturate
				if (byte_cnt == 3'd0) begin
					cmd <= byte_in;
				end else begin
					case (cmd)
						cmd_status: if (byte_cnt == status_bytes)
							io.status <= {byte_in, pbuf}; // whole word at once
						cmd_joy0: if (byte_cnt == 3'd1)
							io.joystick_0 <= byte_in;
						cmd_joy1: if (byte_cnt == 3'd1)
							io.joystick_1 <= byte_in;
						cmd_key: if (byte_cnt == 3'd2) begin
							io.key_code    <= pbuf[23:16];
							io.key_pressed <= byte_in[0];
							io.key_toggle  <= ~io.key_toggle;
						end
						default: ; // unknown command
					endcase
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== user_io_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface user_io_if;
	logic [31:0] status;
	logic [7:0]  joystick_0;
	logic [7:0]  joystick_1;
	logic [7:0]  key_code;
	logic        key_pressed;
	logic        key_toggle; // flips once per key event

	modport host (
		output status,
		output joystick_0,
		output joystick_1,
		output key_code,
		output key_pressed,
		output key_toggle
	);

	modport user (
		input status,
		input joystick_0,
		input joystick_1,
		input key_code,
		input key_pressed,
		input key_toggle
	);
endinterface

`default_nettype wire

// ==== video_blank_dim.sv ====
`timescale 1ns/100ps
`default_nettype none

module video_blank_dim import arcade_io_pkg::*; (
	input  logic                 clock_24,
	input  logic                 rst_n,
	input  logic                 ce_pix,
	input  logic [1:0]           scanlines,
	input  logic [rg_width-1:0]  r,
	input  logic [rg_width-1:0]  g,
	input  logic [b_width-1:0]   b,
	input  logic                 hb,
	input  logic                 vb,
	input  logic                 hs,
	input  logic                 vs,
	output logic [vga_width-1:0] vga_r,
	output logic [vga_width-1:0] vga_g,
	output logic [vga_width-1:0] vga_b,
	output logic                 vga_hs,
	output logic                 vga_vs
);
	logic                 odd_line;
	logic [1:0]           mode;
	logic [vga_width-1:0] r_exp;
	logic [vga_width-1:0] g_exp;
	logic [vga_width-1:0] b_exp;

	function automatic logic [vga_width-1:0] dim(input logic [vga_width-1:0] v,
			input logic [1:0] m);
		case (m)
			scan_none: dim = v;
			scan_25:   dim = v - (v >> 2);
			scan_50:   dim = v >> 1;
			scan_75:   dim = v >> 2;
		endcase
	endfunction

	// bit repeat up to 6 bits
	assign r_exp = {r, r};
	assign g_exp = {g, g};
	assign b_exp = {b, b, b};
	assign mode  = odd_line ? scanlines : scan_none;

	always_ff @(posedge clock_24) begin
		if (!rst_n) begin
			odd_line <= 1'b0;
			vga_r    <= '0;
			vga_g    <= '0;
			vga_b    <= '0;
			vga_hs   <= 1'b0;
			vga_vs   <= 1'b0;
		end else if (ce_pix) begin
			if (vs)
				odd_line <= 1'b0;
			else if (hs && !vga_hs) // vga_hs holds last hs
				odd_line <= ~odd_line;
			vga_hs <= hs;
			vga_vs <= vs;
			if (hb || vb) begin
				vga_r <= '0;
				vga_g <= '0;
				vga_b <= '0;
			end else begin
				vga_r <= dim(r_exp, mode);
				vga_g <= dim(g_exp, mode);
				vga_b <= dim(b_exp, mode);
			end
		end
	end

endmodule

`default_nettype wire
